// File: patl_proc.f
+incdir+include
design/patl_pkg.sv
design/patl_alu.sv
design/patl_checksum.sv
design/patl_regfile.sv
design/patl_sequencer.sv
design/patl_proc.sv
test/patl_proc_tb.sv

// File: test/patl_proc_tb.sv
`timescale 1ns/1ps
// testbench for the microcoded packet processor
// drives header plus payload frames, models seq byte and checksum close,
// compares the collected output stream byte by byte
module patl_proc_tb;

	localparam int LAST_PORT   = 7;    // highest forwarded port
	localparam int MAX_CYCLES  = 4000; // frame bytes x stall factor + margin
	localparam int STREAM_WAIT = 400;  // per-check wait for output bytes

	logic       clk;
	logic       srst;
	logic [7:0] in_data;
	logic       in_sof;
	logic       in_eof;
	logic       in_src_rdy;
	logic       out_dst_rdy;
	logic       in_dst_rdy;
	logic [7:0] out_data;
	logic       out_sof;
	logic       out_eof;
	logic       out_src_rdy;
	logic [3:0] outport_addr;

	logic [7:0] payload_q [$]; // payload of the frame being built
	logic [9:0] exp_q [$];     // {eof, sof, data}
	logic [9:0] rx_q [$];
	logic [7:0] exp_seq;
	integer     seed;
	integer     bp_seed;
	bit         gap_on;        // random source gaps
	bit         bp_on;         // random out_dst_rdy
	int         cycle_cnt;
	int         checks;
	int         errors;
	int         test_errors;
	int         tests;

	patl_proc patl_proc_i (
		.clk(clk), .srst(srst),
		.in_data(in_data), .in_sof(in_sof), .in_eof(in_eof), .in_src_rdy(in_src_rdy),
		.out_dst_rdy(out_dst_rdy), .in_dst_rdy(in_dst_rdy),
		.out_data(out_data), .out_sof(out_sof), .out_eof(out_eof),
		.out_src_rdy(out_src_rdy), .outport_addr(outport_addr)
	);

	always #10 clk = ~clk; // 20 ns period

	always
	begin
		@(posedge clk);
		#2;
		out_dst_rdy = bp_on ? 1'($random(bp_seed)) : 1'b1; // half rate when stalling
	end

	// one entry per output transfer, taken at the stable midpoint
	always @(negedge clk)
	begin
		if (!srst && out_src_rdy && out_dst_rdy)
			rx_q.push_back({out_eof, out_sof, out_data});
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic compare_value(input string sig, input logic [7:0] want,
		input logic [7:0] got);
		checks++;
		assert (got === want)
		else
		begin
			$display("Mismatch at %0t: %s expected %02h got %02h", $time, sig, want, got);
			errors++;
		end
	endtask

	// reset held 8 edges; optional idle check once the first edge is past
	task automatic apply_reset(input bit check_idle);
		srst = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clk);
			#1;
			if (check_idle)
			begin
				compare_value("out_src_rdy", 8'd0, {7'd0, out_src_rdy});
				compare_value("in_dst_rdy", 8'd0, {7'd0, in_dst_rdy});
				compare_value("outport_addr", 8'd0, {4'd0, outport_addr});
			end
		end
		#1;
		srst = 1'b0; // lands at edge + 2
		exp_seq = 8'd0;
	endtask

	task automatic fill_payload(input int len);
		payload_q.delete();
		repeat (len)
			payload_q.push_back(8'($random(seed)));
	endtask

	// entered and left 2 ns after an edge with in_src_rdy low
	task automatic send_byte(input logic [7:0] data, input logic sof, input logic eof);
		int gap;
		gap = gap_on ? ($random(seed) & 3) : 0;
		repeat (gap)
		begin
			@(posedge clk);
			#2;
		end
		in_data    = data;
		in_sof     = sof;
		in_eof     = eof;
		in_src_rdy = 1'b1;
		do
			@(negedge clk);
		while (!in_dst_rdy); // transfer on the coming edge
		@(posedge clk);
		#2;
		in_src_rdy = 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] header, input int count);
		send_byte(header, 1'b1, 1'b0);
		for (int i = 0; i < count; i++)
			send_byte(payload_q[i], 1'b0, i == payload_q.size() - 1);
	endtask

	// seq byte, payload as is, then inverted ones-complement sum hi then lo
	task automatic expect_frame(input logic [7:0] header);
		logic [31:0] acc;
		logic [15:0] sum;
		logic [15:0] pair;
		int          n;
		n   = payload_q.size();
		acc = 32'd0;
		if (header <= LAST_PORT)
		begin
			exp_q.push_back({2'b01, exp_seq});
			for (int i = 0; i < n; i++)
				exp_q.push_back({2'b00, payload_q[i]});
			for (int i = 0; i < n; i += 2)
			begin
				pair = {payload_q[i], (i + 1 < n) ? payload_q[i + 1] : 8'h00}; // zero pad
				acc  = acc + {16'd0, pair}; // plain sum, carries folded below
			end
			while (acc[31:16] != 16'd0)
				acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]}; // end-around carry
			sum = ~acc[15:0];
			exp_q.push_back({2'b00, sum[15:8]});
			exp_q.push_back({2'b10, sum[7:0]});
			exp_seq++;
		end
	endtask

	task automatic check_stream();
		int waited;
		int n;
		waited = 0;
		while (rx_q.size() < exp_q.size() && waited < STREAM_WAIT)
		begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk); // room for stray extra bytes
		#2; // back to the drive point
		checks++;
		assert (rx_q.size() == exp_q.size())
		else
		begin
			$display("output stream has %0d bytes where %0d were expected",
				rx_q.size(), exp_q.size());
			errors++;
		end
		n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
		begin
			compare_value("out_data", exp_q[i][7:0], rx_q[i][7:0]);
			compare_value("out_sof", {7'd0, exp_q[i][8]}, {7'd0, rx_q[i][8]});
			compare_value("out_eof", {7'd0, exp_q[i][9]}, {7'd0, rx_q[i][9]});
		end
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == test_errors)
			$display("test %0d %s: pass", tests, name);
		else
			$display("test %0d %s: fail with %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic forward_frame(input logic [7:0] header, input int len);
		fill_payload(len);
		expect_frame(header);
		send_frame(header, len);
	endtask

	task automatic even_frame_test();
		forward_frame(8'd3, 8);
		check_stream();
		compare_value("outport_addr", 8'd3, {4'd0, outport_addr});
		report_test("even frame to port 3");
	endtask

	task automatic odd_frame_test();
		forward_frame(8'd6, 7);
		check_stream();
		report_test("odd frame with pad byte");
	endtask

	task automatic drop_one(input logic [7:0] header, input int len);
		forward_frame(header, len); // model adds nothing for a drop
		repeat (10) @(posedge clk);
		#2;
		checks++;
		assert (rx_q.size() == 0)
		else
		begin
			$display("frame with header %02h was not dropped, %0d bytes came out",
				header, rx_q.size());
			errors++;
		end
		rx_q.delete();
	endtask

	task automatic drop_frame_test();
		drop_one(8'd9, 5);
		drop_one(8'hc4, 2);
		forward_frame(8'd0, 4); // seq continues after the drops
		check_stream();
		report_test("out of range header dropped");
	endtask

	task automatic stall_test();
		gap_on = 1'b1;
		bp_on  = 1'b1;
		for (int f = 0; f < 5; f++)
			forward_frame(8'($random(seed) & 7), 3 + ($random(seed) & 7));
		check_stream();
		gap_on = 1'b0;
		bp_on  = 1'b0;
		report_test("source gaps and back-pressure");
	endtask

	task automatic mid_reset_test();
		fill_payload(6);
		send_frame(8'd5, 3); // eof never sent
		repeat (3) @(posedge clk);
		#2;
		apply_reset(1'b1);
		rx_q.delete();
		exp_q.delete();
		compare_value("outport_addr", 8'd0, {4'd0, outport_addr});
		forward_frame(8'd2, 5);
		check_stream();
		compare_value("outport_addr", 8'd2, {4'd0, outport_addr});
		report_test("reset in mid frame");
	endtask

	initial
	begin
		clk         = 1'b0;
		srst        = 1'b1;
		in_data     = 8'h00;
		in_sof      = 1'b0;
		in_eof      = 1'b0;
		in_src_rdy  = 1'b0;
		out_dst_rdy = 1'b1;
		seed        = 32'hacaf6459;
		bp_seed     = 32'hacaf6459;
		gap_on      = 1'b0;
		bp_on       = 1'b0;
		cycle_cnt   = 0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		tests       = 0;
		exp_seq     = 8'd0;
		apply_reset(1'b0);
		even_frame_test();
		odd_frame_test();
		drop_frame_test();
		stall_test();
		mid_reset_test();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: design/patl_proc.sv
`timescale 1ns/1ps
// microcoded packet processor, top level
// datapath muxes, byte pair assembler, flag and output port registers
module patl_proc
(
	input  logic            clk,
	input  logic            srst,
	input  patl_pkg::byte_t in_data,
	input  logic            in_sof,
	input  logic            in_eof,
	input  logic            in_src_rdy,
	input  logic            out_dst_rdy,
	output logic            in_dst_rdy,
	output patl_pkg::byte_t out_data,
	output logic            out_sof,
	output logic            out_eof,
	output logic            out_src_rdy,
	output patl_pkg::port_t outport_addr
);
	import patl_pkg::*;

	data_sel_e data_sel;
	logic      op0_sel;
	logic      op1_sel;
	alu_op_e   alu_op;
	cmp_mode_e cmp_mode;
	logic      byte_mode;
	reg_addr_t reg_addr;
	logic [1:0] reg_wen;
	logic      word_load;
	logic      csum_add;
	logic      csum_clear;
	logic      flag_en;
	logic      outport_en;
	word_t     const_word;
	logic      cmp_res;
	logic      csum_zero;
	logic      in_xfer;
	word_t     word_reg;   // last two input bytes
	word_t     main_data;  // main mux
	word_t     reg_data;
	word_t     csum_data;
	word_t     alu_res;
	word_t     op0_data;
	word_t     op1_data;
	byte_t     flag_reg;
	port_t     outport_reg;

	patl_sequencer patl_sequencer_i (
		.clk(clk), .srst(srst),
		.in_sof(in_sof), .in_eof(in_eof), .in_src_rdy(in_src_rdy),
		.out_dst_rdy(out_dst_rdy), .cmp_res(cmp_res), .csum_zero(csum_zero),
		.in_dst_rdy(in_dst_rdy), .out_sof(out_sof), .out_eof(out_eof),
		.out_src_rdy(out_src_rdy), .data_sel(data_sel), .op0_sel(op0_sel),
		.op1_sel(op1_sel), .alu_op(alu_op), .cmp_mode(cmp_mode), .byte_mode(byte_mode),
		.reg_addr(reg_addr), .reg_wen(reg_wen), .word_load(word_load),
		.csum_add(csum_add), .csum_clear(csum_clear), .flag_en(flag_en),
		.outport_en(outport_en), .const_word(const_word)
	);

	patl_regfile patl_regfile_i (
		.clk(clk), .srst(srst), .wren_low(reg_wen[0]), .wren_high(reg_wen[1]),
		.address(reg_addr), .data_in(main_data), .data_out(reg_data)
	);

	patl_checksum patl_checksum_i (
		.clk(clk), .srst(srst), .data_in(word_reg), // pairs straight from the assembler
		.checksum_add(csum_add), .checksum_clear(csum_clear),
		.checksum_check(csum_zero), .checksum_out(csum_data)
	);

	patl_alu patl_alu_i (
		.op0(op0_data), .op1(op1_data), .op(alu_op), .byte_mode(byte_mode),
		.mode(cmp_mode), .res(alu_res), .result(cmp_res)
	);

	assign in_xfer = in_src_rdy & in_dst_rdy;

	// a load with no input transfer shifts in the zero pad byte
	always_ff @(posedge clk)
	begin
		if (word_load)
			word_reg <= {word_reg[7:0], in_xfer ? in_data : 8'h00};
	end

	always_comb
	begin
		case (data_sel)
			DS_CONST: main_data = const_word;
			DS_CSUM:  main_data = csum_data;
			DS_REG:   main_data = reg_data;
			DS_WORD:  main_data = word_reg;
			DS_BYTE:  main_data = {8'h00, word_reg[7:0]};
			DS_ALU:   main_data = alu_res;
			DS_FLAGS: main_data = {8'h00, flag_reg};
			default:  main_data = '0;
		endcase
	end

	assign op0_data = op0_sel ? reg_data : word_reg;
	assign op1_data = op1_sel ? reg_data : const_word;
	assign out_data = byte_mode ? main_data[7:0] : main_data[15:8]; // lane select

	always_ff @(posedge clk)
	begin
		if (srst)
		begin
			flag_reg    <= '0;
			outport_reg <= '0;
		end
		else
		begin
			if (flag_en)
				flag_reg <= {4'b0000, csum_zero, cmp_res, in_eof, in_sof};
			if (outport_en)
				outport_reg <= main_data[3:0]; // header low nibble
		end
	end

	assign outport_addr = outport_reg;

	// stalled output byte stays put until taken
	out_hold_a: assert property (@(posedge clk) disable iff (srst)
		out_src_rdy && !out_dst_rdy |=> out_src_rdy && $stable(out_data));

endmodule

// File: design/patl_sequencer.sv
`timescale 1ns/1ps
// microcode sequencer of the packet processor
// reads the constant program, decodes datapath controls,
// stalls on stream waits and branches on compare, eof, sof or checksum
module patl_sequencer
(
	input  logic                  clk,
	input  logic                  srst,
	input  logic                  in_sof,
	input  logic                  in_eof,
	input  logic                  in_src_rdy,
	input  logic                  out_dst_rdy,
	input  logic                  cmp_res,
	input  logic                  csum_zero,
	output logic                  in_dst_rdy,
	output logic                  out_sof,
	output logic                  out_eof,
	output logic                  out_src_rdy,
	output patl_pkg::data_sel_e   data_sel,
	output logic                  op0_sel,
	output logic                  op1_sel,
	output patl_pkg::alu_op_e     alu_op,
	output patl_pkg::cmp_mode_e   cmp_mode,
	output logic                  byte_mode,
	output patl_pkg::reg_addr_t   reg_addr,
	output logic [1:0]            reg_wen,
	output logic                  word_load,
	output logic                  csum_add,
	output logic                  csum_clear,
	output logic                  flag_en,
	output logic                  outport_en,
	output patl_pkg::word_t       const_word
);
	import patl_pkg::*;

	`include "patl_ucode.svh"

	pc_t    pc;
	pc_t    pc_next;
	instr_t cur;
	logic   in_xfer;
	logic   out_xfer;
	logic   advance;
	logic   take;

	assign cur = UCODE[pc]; // rom lookup

	// handshakes come from the program only, never from the peer's ready
	assign in_dst_rdy  = cur.in_wait;
	assign out_src_rdy = cur.out_wait;
	assign out_sof     = cur.out_sof;
	assign out_eof     = cur.out_eof;

	assign in_xfer  = cur.in_wait & in_src_rdy;
	assign out_xfer = cur.out_wait & out_dst_rdy;
	assign advance  = (~cur.in_wait | in_xfer) & (~cur.out_wait | out_xfer); // no stall

	always_comb
	begin
		case (cur.br_cond)
			BR_ALWAYS: take = 1'b1;
			BR_CMP:    take = cmp_res;   // same-cycle compare
			BR_EOF:    take = in_eof;    // only sampled on a transfer
			BR_ZERO:   take = csum_zero;
			BR_NSOF:   take = ~in_sof;   // stray byte, stay put
			default:   take = 1'b0;
		endcase
	end

	assign pc_next = take ? cur.target : pc_t'(pc + 1'b1);

	always_ff @(posedge clk)
	begin
		if (srst)
			pc <= '0;
		else if (advance)
			pc <= pc_next; // held while waiting
	end

	// plain decode
	assign data_sel   = cur.data_sel;
	assign op0_sel    = cur.op0_sel;
	assign op1_sel    = cur.op1_sel;
	assign alu_op     = cur.alu_op;
	assign cmp_mode   = cur.cmp_mode;
	assign byte_mode  = cur.byte_mode;
	assign reg_addr   = cur.reg_addr;
	assign const_word = {10'd0, cur.imm}; // zero-extended immediate

	// state-changing controls fire once, on the cycle the instruction retires
	assign reg_wen    = cur.reg_wen & {2{advance}};
	assign word_load  = cur.word_load & advance;
	assign csum_add   = cur.csum_add & advance;
	assign csum_clear = cur.csum_clear & advance;
	assign flag_en    = cur.flag_en & advance;
	assign outport_en = cur.outport_en & advance;

	pc_range_a: assert property (@(posedge clk) disable iff (srst)
		pc_next <= PC_DROP_NEXT); // last programmed entry

	eof_valid_a: assert property (@(posedge clk) disable iff (srst)
		out_eof |-> out_src_rdy);

endmodule

// File: design/patl_regfile.sv
`timescale 1ns/1ps
// sixteen-word register file
// byte-wide write enables, combinational read
module patl_regfile
(
	input  logic                clk,
	input  logic                srst,
	input  logic                wren_low,
	input  logic                wren_high,
	input  patl_pkg::reg_addr_t address,
	input  patl_pkg::word_t     data_in,
	output patl_pkg::word_t     data_out
);
	import patl_pkg::*;

	word_t mem [REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (srst)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				mem[i] <= '0; // sequence counter restarts at 0
		end
		else
		begin
			if (wren_low)
				mem[address][7:0] <= data_in[7:0];
			if (wren_high)
				mem[address][15:8] <= data_in[15:8];
		end
	end

	assign data_out = mem[address]; // async read

endmodule

// File: design/patl_checksum.sv
`timescale 1ns/1ps
// ones-complement checksum accumulator
// end-around carry add, complemented output, all-ones detect
module patl_checksum
(
	input  logic            clk,
	input  logic            srst,
	input  patl_pkg::word_t data_in,
	input  logic            checksum_add,
	input  logic            checksum_clear,
	output logic            checksum_check,
	output patl_pkg::word_t checksum_out
);
	import patl_pkg::*;

	word_t       sum;
	logic [16:0] total;

	assign total = {1'b0, sum} + {1'b0, data_in}; // carry in bit 16

	always_ff @(posedge clk)
	begin
		if (srst || checksum_clear)
			sum <= '0;
		else if (checksum_add)
			sum <= total[15:0] + word_t'(total[16]); // wrap the carry back in
	end

	assign checksum_out   = ~sum;
	assign checksum_check = &sum; // complement is zero

	add_clear_a: assert property (@(posedge clk) disable iff (srst)
		!(checksum_add && checksum_clear));

endmodule

// File: design/patl_alu.sv
`timescale 1ns/1ps
// datapath alu with result comparator
// add, subtract, and, or; byte mode drops the upper operand bytes
// comparator tests the result, sign bit for the ordered modes
module patl_alu
(
	input  patl_pkg::word_t     op0,
	input  patl_pkg::word_t     op1,
	input  patl_pkg::alu_op_e   op,
	input  logic                byte_mode,
	input  patl_pkg::cmp_mode_e mode,
	output patl_pkg::word_t     res,
	output logic                result
);
	import patl_pkg::*;

	word_t a;
	word_t b;

	assign a = byte_mode ? {8'h00, op0[7:0]} : op0; // masked high byte
	assign b = byte_mode ? {8'h00, op1[7:0]} : op1;

	always_comb
	begin
		case (op)
			ALU_ADD: res = a + b;
			ALU_SUB: res = a - b; // borrow lands in bit 15
			ALU_AND: res = a & b;
			ALU_OR:  res = a | b;
			default: res = '0;
		endcase
	end

	// header minus limit is negative for forwarded ports
	always_comb
	begin
		case (mode)
			CMP_EQ:  result = (res == '0);
			CMP_NE:  result = (res != '0);
			CMP_LT:  result = res[15];
			CMP_GE:  result = ~res[15];
			default: result = 1'b0;
		endcase
	end

endmodule

// File: design/patl_pkg.sv
// shared types and constants of the packet processor
// stream and datapath widths, control encodings, microinstruction layout
package patl_pkg;

	typedef logic [7:0]  byte_t;     // stream byte
	typedef logic [15:0] word_t;     // datapath word
	typedef logic [3:0]  reg_addr_t; // register file index
	typedef logic [3:0]  port_t;     // output port number
	typedef logic [5:0]  pc_t;       // microprogram address

	localparam int        UCODE_DEPTH = 64;
	localparam int        REG_COUNT   = 16;
	localparam int        MAX_PORT    = 7;    // highest forwarded port
	localparam reg_addr_t SEQ_REG     = 4'd1; // holds the sequence counter

	// branch conditions
	localparam logic [2:0] BR_NONE   = 3'd0;
	localparam logic [2:0] BR_ALWAYS = 3'd1;
	localparam logic [2:0] BR_CMP    = 3'd2; // comparator true
	localparam logic [2:0] BR_EOF    = 3'd3; // eof on the input transfer
	localparam logic [2:0] BR_ZERO   = 3'd4; // checksum complement is zero
	localparam logic [2:0] BR_NSOF   = 3'd5; // input byte without sof

	typedef enum logic [2:0] {
		DS_CONST, // immediate
		DS_CSUM,  // checksum complement
		DS_REG,   // register file read
		DS_WORD,  // assembled byte pair
		DS_BYTE,  // last input byte
		DS_ALU,
		DS_FLAGS,
		DS_ZERO
	} data_sel_e;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_e;

	typedef enum logic [1:0] {CMP_EQ, CMP_NE, CMP_LT, CMP_GE} cmp_mode_e;

	// 40-bit microinstruction
	typedef struct packed {
		logic        in_wait;   // hold until input transfer
		logic        out_wait;  // hold until output transfer
		logic        out_sof;
		logic        out_eof;
		logic [2:0]  br_cond;
		pc_t         target;
		data_sel_e   data_sel;
		logic        op0_sel;   // word or register
		logic        op1_sel;   // immediate or register
		alu_op_e     alu_op;
		cmp_mode_e   cmp_mode;
		logic        byte_mode; // low byte lane only
		reg_addr_t   reg_addr;
		logic [1:0]  reg_wen;   // high, low byte
		logic        word_load;
		logic        csum_add;
		logic        csum_clear;
		logic        flag_en;
		logic        outport_en;
		logic [5:0]  imm;
	} instr_t;

endpackage

// File: include/patl_ucode.svh
// constant microprogram for the packet processor
// header test, sequence byte, payload pass-through, checksum close, drop path
`ifndef PATL_UCODE_SVH
`define PATL_UCODE_SVH

localparam pc_t PC_INIT      = 6'd0;  // per-frame setup
localparam pc_t PC_HEAD      = 6'd1;  // header byte, resync on sof
localparam pc_t PC_TEST      = 6'd2;  // port range check
localparam pc_t PC_PORT      = 6'd3;
localparam pc_t PC_SEQ       = 6'd4;
localparam pc_t PC_INC       = 6'd5;
localparam pc_t PC_A_IN      = 6'd6;  // first byte of a checksum pair
localparam pc_t PC_A_OUT     = 6'd7;
localparam pc_t PC_B_IN      = 6'd8;  // second byte of a pair
localparam pc_t PC_B_OUT     = 6'd9;
localparam pc_t PC_A_LAST    = 6'd10; // odd length, pad shift follows
localparam pc_t PC_SUM       = 6'd11;
localparam pc_t PC_CS_HI     = 6'd12;
localparam pc_t PC_CS_LO     = 6'd13;
localparam pc_t PC_B_LAST    = 6'd14;
localparam pc_t PC_DROP      = 6'd15; // swallow bytes up to eof
localparam pc_t PC_DROP_NEXT = 6'd16;

localparam instr_t UCODE [UCODE_DEPTH] = '{
	PC_INIT: '{csum_clear: 1'b1, data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_HEAD: '{in_wait: 1'b1, word_load: 1'b1, flag_en: 1'b1, br_cond: BR_NSOF, target: PC_HEAD,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_TEST: '{imm: 6'(MAX_PORT + 1), byte_mode: 1'b1, br_cond: BR_CMP, target: PC_DROP,
		data_sel: DS_ALU, alu_op: ALU_SUB, cmp_mode: CMP_GE, default: '0},
	PC_PORT: '{outport_en: 1'b1, data_sel: DS_WORD, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_SEQ: '{out_wait: 1'b1, out_sof: 1'b1, byte_mode: 1'b1, reg_addr: SEQ_REG,
		data_sel: DS_REG, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_INC: '{op0_sel: 1'b1, imm: 6'd1, byte_mode: 1'b1, reg_addr: SEQ_REG, reg_wen: 2'b11,
		data_sel: DS_ALU, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_A_IN: '{in_wait: 1'b1, word_load: 1'b1, br_cond: BR_EOF, target: PC_A_LAST,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_A_OUT: '{out_wait: 1'b1, byte_mode: 1'b1,
		data_sel: DS_BYTE, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_B_IN: '{in_wait: 1'b1, word_load: 1'b1, br_cond: BR_EOF, target: PC_B_LAST,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_B_OUT: '{out_wait: 1'b1, byte_mode: 1'b1, csum_add: 1'b1, br_cond: BR_ALWAYS,
		target: PC_A_IN, data_sel: DS_BYTE, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_A_LAST: '{out_wait: 1'b1, byte_mode: 1'b1, word_load: 1'b1,
		data_sel: DS_BYTE, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_SUM: '{csum_add: 1'b1, data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_CS_HI: '{out_wait: 1'b1, data_sel: DS_CSUM, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_CS_LO: '{out_wait: 1'b1, out_eof: 1'b1, byte_mode: 1'b1, br_cond: BR_ALWAYS,
		target: PC_INIT, data_sel: DS_CSUM, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_B_LAST: '{out_wait: 1'b1, byte_mode: 1'b1, br_cond: BR_ALWAYS, target: PC_SUM,
		data_sel: DS_BYTE, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_DROP: '{in_wait: 1'b1, br_cond: BR_EOF, target: PC_INIT,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	PC_DROP_NEXT: '{br_cond: BR_ALWAYS, target: PC_DROP,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0},
	default: '{br_cond: BR_ALWAYS, target: PC_INIT,
		data_sel: DS_ZERO, alu_op: ALU_ADD, cmp_mode: CMP_EQ, default: '0}
};

`endif
